/* rtl/i2c_eeprom_pkg.sv */
`default_nettype none

package i2c_eeprom_pkg;

    localparam int ADDR_W      = 11;
    localparam int DATA_W      = 8;
    localparam int SCL_QUARTER = 4;       // clk cycles per quarter bit, 16 per bus bit

    localparam logic [3:0] DEVICE_CODE = 4'b1010;   // 24C16 family

    typedef enum logic
    {
        OP_WRITE,
        OP_READ
    } eeprom_op_e;

    // host side
    typedef struct packed
    {
        eeprom_op_e          op;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   data;
    } eeprom_req_t;

    typedef struct packed
    {
        eeprom_op_e          op;
        logic [DATA_W-1:0]   data;  // zero for writes
        logic                nack;  // device did not answer
    } eeprom_rsp_t;

    // byte level bus commands
    typedef enum logic [1:0]
    {
        PHY_START,
        PHY_STOP,
        PHY_WRITE,
        PHY_READ
    } phy_cmd_e;

    typedef struct packed
    {
        phy_cmd_e            cmd;
        logic [DATA_W-1:0]   data;
        logic                last;  // read only, answer with nack
    } phy_cmd_t;

    typedef struct packed
    {
        logic [DATA_W-1:0]   data;
        logic                nack;
    } phy_rsp_t;

endpackage

`default_nettype wire

/* rtl/i2c_byte_phy.sv */
`default_nettype none

module i2c_byte_phy
(
    input  wire logic                       CLK,
    input  wire logic                       RESET,
    input  wire logic                       cmd_valid,
    input  wire i2c_eeprom_pkg::phy_cmd_t   cmd,
    output logic                            cmd_ready,
    output logic                            done,
    output i2c_eeprom_pkg::phy_rsp_t        result,
    output logic                            scl,
    output logic                            sda_pull_low,
    input  wire logic                       sda_in
);

    import i2c_eeprom_pkg::*;

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_START,
        ST_STOP,
        ST_BIT
    } phy_state_e;

    phy_state_e                         state;
    logic [$clog2(SCL_QUARTER)-1:0]     qcnt;
    logic [1:0]                         phase;      // 0 low, 1 high, 2 high, 3 low
    logic [3:0]                         bit_cnt;    // 8 is the ack slot
    logic [DATA_W-1:0]                  shift;
    logic                               is_read;
    logic                               last;
    logic                               nack_r;

    logic                               quarter_end;
    logic                               cmd_end;
    logic [1:0]                         phase_nxt;
    logic [3:0]                         bit_nxt;
    logic                               tx_bit;
    logic                               scl_nxt;
    logic                               sda_nxt;

    assign cmd_ready   = (state == ST_IDLE);
    assign quarter_end = (int'(qcnt) == SCL_QUARTER - 1);
    assign cmd_end     = (phase == 2'd3) && ((state != ST_BIT) || (bit_cnt == 4'd8));

    assign result.data = shift;
    assign result.nack = nack_r;

    // bus levels for the quarter about to begin
    always_comb
    begin
        phase_nxt = phase + 2'd1;
        bit_nxt   = (phase == 2'd3) ? bit_cnt + 4'd1 : bit_cnt;
        tx_bit    = (phase == 2'd3) ? shift[DATA_W-2] : shift[DATA_W-1];
        scl_nxt   = scl;
        sda_nxt   = sda_pull_low;
        case (state)
            ST_START:
            begin
                scl_nxt = (phase_nxt == 2'd1) || (phase_nxt == 2'd2);
                sda_nxt = (phase_nxt >= 2'd2);    // falls while scl high
            end
            ST_STOP:
            begin
                scl_nxt = (phase_nxt != 2'd0);
                sda_nxt = (phase_nxt < 2'd2);     // rises while scl high
            end
            ST_BIT:
            begin
                scl_nxt = (phase_nxt == 2'd1) || (phase_nxt == 2'd2);
                if (bit_nxt == 4'd8)
                    sda_nxt = is_read & ~last;    // master ack on reads
                else
                    sda_nxt = ~is_read & ~tx_bit;
            end
            default:
            begin
                scl_nxt = scl;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state        <= ST_IDLE;
            qcnt         <= '0;
            phase        <= '0;
            bit_cnt      <= '0;
            done         <= 1'b0;
            scl          <= 1'b1;
            sda_pull_low <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (state == ST_IDLE)
            begin
                qcnt    <= '0;
                phase   <= '0;
                bit_cnt <= '0;
                if (cmd_valid)
                begin
                    scl <= 1'b0;
                    case (cmd.cmd)
                        PHY_START:
                        begin
                            state        <= ST_START;
                            sda_pull_low <= 1'b0;
                        end
                        PHY_STOP:
                        begin
                            state        <= ST_STOP;
                            sda_pull_low <= 1'b1;
                        end
                        default:
                        begin
                            state        <= ST_BIT;
                            sda_pull_low <= (cmd.cmd == PHY_WRITE) & ~cmd.data[DATA_W-1];
                        end
                    endcase
                end
            end
            else
            begin
                qcnt <= quarter_end ? '0 : qcnt + 1'b1;
                if (quarter_end)
                begin
                    if (cmd_end)
                    begin
                        state <= ST_IDLE;   // lines keep their last levels
                        done  <= 1'b1;
                    end
                    else
                    begin
                        phase        <= phase_nxt;
                        bit_cnt      <= bit_nxt;
                        scl          <= scl_nxt;
                        sda_pull_low <= sda_nxt;
                    end
                end
            end
        end
    end

    // data path
    always_ff @(posedge CLK)
    begin
        if ((state == ST_IDLE) && cmd_valid)
        begin
            shift   <= cmd.data;
            is_read <= (cmd.cmd == PHY_READ);
            last    <= cmd.last;
            nack_r  <= 1'b0;
        end
        else if ((state == ST_BIT) && quarter_end)
        begin
            if ((phase == 2'd1) && (bit_cnt == 4'd8) && !is_read)
                nack_r <= sda_in;                       // high means no ack
            else if ((phase == 2'd1) && (bit_cnt != 4'd8) && is_read)
                shift <= {shift[DATA_W-2:0], sda_in};
            else if ((phase == 2'd3) && !is_read)
                shift <= {shift[DATA_W-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

/* rtl/eeprom_ctrl.sv */
`default_nettype none

module eeprom_ctrl
(
    input  wire logic                           CLK,
    input  wire logic                           RESET,
    input  wire logic                           req_valid,
    input  wire i2c_eeprom_pkg::eeprom_req_t    req,
    output logic                                req_ready,
    output logic                                rsp_valid,
    output i2c_eeprom_pkg::eeprom_rsp_t         rsp,
    input  wire logic                           rsp_ready,
    output logic                                cmd_valid,
    output i2c_eeprom_pkg::phy_cmd_t            cmd,
    input  wire logic                           cmd_ready,
    input  wire logic                           done,
    input  wire i2c_eeprom_pkg::phy_rsp_t       result
);

    import i2c_eeprom_pkg::*;

    typedef enum logic [3:0]
    {
        CS_IDLE,
        CS_START,
        CS_CTRL_WR,
        CS_ADDR,
        CS_DATA,
        CS_RESTART,
        CS_CTRL_RD,
        CS_READ,
        CS_STOP,
        CS_RESPOND
    } ctrl_state_e;

    ctrl_state_e    state;
    logic           issued;     // current phy command accepted, waiting for done
    eeprom_req_t    req_q;

    assign req_ready = (state == CS_IDLE);
    assign rsp_valid = (state == CS_RESPOND);
    assign cmd_valid = (state != CS_IDLE) && (state != CS_RESPOND) && !issued;

    // phy command for the current step
    always_comb
    begin
        cmd.cmd  = PHY_START;
        cmd.data = '0;
        cmd.last = 1'b0;
        case (state)
            CS_CTRL_WR:
            begin
                cmd.cmd  = PHY_WRITE;
                cmd.data = {DEVICE_CODE, req_q.addr[ADDR_W-1:DATA_W], 1'b0};
            end
            CS_ADDR:
            begin
                cmd.cmd  = PHY_WRITE;
                cmd.data = req_q.addr[DATA_W-1:0];
            end
            CS_DATA:
            begin
                cmd.cmd  = PHY_WRITE;
                cmd.data = req_q.data;
            end
            CS_CTRL_RD:
            begin
                cmd.cmd  = PHY_WRITE;
                cmd.data = {DEVICE_CODE, req_q.addr[ADDR_W-1:DATA_W], 1'b1};
            end
            CS_READ:
            begin
                cmd.cmd  = PHY_READ;
                cmd.last = 1'b1;    // single byte, end with nack
            end
            CS_STOP:
            begin
                cmd.cmd = PHY_STOP;
            end
            default:
            begin
                cmd.cmd = PHY_START;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state  <= CS_IDLE;
            issued <= 1'b0;
        end
        else
        begin
            if (cmd_valid && cmd_ready)
                issued <= 1'b1;

            case (state)
                CS_IDLE:
                begin
                    if (req_valid)
                        state <= CS_START;
                end
                CS_RESPOND:
                begin
                    if (rsp_ready)
                        state <= CS_IDLE;
                end
                default:
                begin
                    if (done)
                    begin
                        issued <= 1'b0;
                        case (state)
                            CS_START:   state <= CS_CTRL_WR;
                            CS_CTRL_WR: state <= result.nack ? CS_STOP : CS_ADDR;
                            CS_ADDR:
                            begin
                                if (result.nack)
                                    state <= CS_STOP;
                                else if (req_q.op == OP_READ)
                                    state <= CS_RESTART;
                                else
                                    state <= CS_DATA;
                            end
                            CS_DATA:    state <= CS_STOP;
                            CS_RESTART: state <= CS_CTRL_RD;
                            CS_CTRL_RD: state <= result.nack ? CS_STOP : CS_READ;
                            CS_READ:    state <= CS_STOP;
                            default:    state <= CS_RESPOND;  // stop finished
                        endcase
                    end
                end
            endcase
        end
    end

    // request latch and held response
    always_ff @(posedge CLK)
    begin
        if ((state == CS_IDLE) && req_valid)
        begin
            req_q    <= req;
            rsp.op   <= req.op;
            rsp.data <= '0;
            rsp.nack <= 1'b0;
        end
        else if (done)
        begin
            if (state == CS_READ)
                rsp.data <= result.data;
            else if (((state == CS_CTRL_WR) || (state == CS_ADDR) || (state == CS_DATA) ||
                      (state == CS_CTRL_RD)) && result.nack)
                rsp.nack <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/i2c_eeprom_top.sv */
`default_nettype none

module i2c_eeprom_top
(
    input  wire logic                           CLK,
    input  wire logic                           RESET,
    input  wire logic                           req_valid,
    input  wire i2c_eeprom_pkg::eeprom_req_t    req,
    output logic                                req_ready,
    output logic                                rsp_valid,
    output i2c_eeprom_pkg::eeprom_rsp_t         rsp,
    input  wire logic                           rsp_ready,
    output logic                                scl,
    output logic                                sda_pull_low,   // open drain, 1 pulls line low
    input  wire logic                           sda_in
);

    import i2c_eeprom_pkg::*;

    logic       cmd_valid;
    logic       cmd_ready;
    phy_cmd_t   cmd;
    logic       done;
    phy_rsp_t   result;

    eeprom_ctrl u_ctrl
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .rsp_ready  (rsp_ready),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_ready  (cmd_ready),
        .done       (done),
        .result     (result)
    );

    i2c_byte_phy u_phy
    (
        .CLK            (CLK),
        .RESET          (RESET),
        .cmd_valid      (cmd_valid),
        .cmd            (cmd),
        .cmd_ready      (cmd_ready),
        .done           (done),
        .result         (result),
        .scl            (scl),
        .sda_pull_low   (sda_pull_low),
        .sda_in         (sda_in)
    );

endmodule

`default_nettype wire

/* testbench/eeprom_model.sv */
`default_nettype none

module eeprom_model
(
    input  wire logic   CLK,
    input  wire logic   RESET,
    input  wire logic   scl,
    input  wire logic   sda,
    input  wire logic   busy,           // refuses the control byte
    output logic        sda_pull_low
);

    typedef enum logic [1:0]
    {
        M_IDLE,
        M_RX,
        M_ACK,
        M_TX
    } model_state_e;

    logic [7:0]     mem [0:2047];
    model_state_e   state;
    logic           scl_q;
    logic           sda_q;
    logic [3:0]     bit_cnt;
    logic [7:0]     shift;
    logic [1:0]     byte_idx;       // 0 control, 1 address, 2 data
    logic           rd;
    logic [10:0]    addr;

    // same fill as the testbench shadow copy
    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] <= 8'(i) ^ {3'(i), 5'(i >> 6)} ^ 8'h5a;
    end

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            state        <= M_IDLE;
            scl_q        <= 1'b1;
            sda_q        <= 1'b1;
            sda_pull_low <= 1'b0;
            bit_cnt      <= '0;
            byte_idx     <= '0;
            rd           <= 1'b0;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl && scl_q && sda_q && !sda)
            begin
                state        <= M_RX;   // start or repeated start
                bit_cnt      <= '0;
                byte_idx     <= '0;
                sda_pull_low <= 1'b0;
            end
            else if (scl && scl_q && !sda_q && sda)
            begin
                state        <= M_IDLE;
                sda_pull_low <= 1'b0;
            end
            else if (scl && !scl_q && (state == M_RX))
            begin
                shift   <= {shift[6:0], sda};
                bit_cnt <= bit_cnt + 4'd1;
            end
            else if (!scl && scl_q)
            begin
                case (state)
                    M_RX:
                    begin
                        if (bit_cnt == 4'd8)
                        begin
                            if ((byte_idx == 2'd0) && ((shift[7:4] != 4'b1010) || busy))
                                state <= M_IDLE;    // no ack, line stays released
                            else
                            begin
                                state        <= M_ACK;
                                sda_pull_low <= 1'b1;
                                byte_idx     <= byte_idx + 2'd1;
                                if (byte_idx == 2'd0)
                                begin
                                    addr[10:8] <= shift[3:1];
                                    rd         <= shift[0];
                                end
                                else if (byte_idx == 2'd1)
                                    addr[7:0] <= shift;
                                else
                                    mem[addr] <= shift;
                            end
                        end
                    end
                    M_ACK:
                    begin
                        bit_cnt <= '0;
                        if (rd)
                        begin
                            state        <= M_TX;
                            shift        <= mem[addr];
                            sda_pull_low <= ~mem[addr][7];
                        end
                        else
                        begin
                            state        <= M_RX;
                            sda_pull_low <= 1'b0;
                        end
                    end
                    M_TX:
                    begin
                        if (bit_cnt == 4'd7)
                        begin
                            state        <= M_IDLE;     // master ack slot ignored
                            sda_pull_low <= 1'b0;
                        end
                        else
                        begin
                            sda_pull_low <= ~shift[6];
                            shift        <= {shift[6:0], 1'b0};
                            bit_cnt      <= bit_cnt + 4'd1;
                        end
                    end
                    default:
                    begin
                        sda_pull_low <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_i2c_eeprom.sv */
`default_nettype none

module tb_i2c_eeprom;

    import i2c_eeprom_pkg::*;

    typedef struct packed
    {
        eeprom_op_e         op;
        logic [ADDR_W-1:0]  addr;
        logic [DATA_W-1:0]  data;
        logic               busy;
        logic [7:0]         stall;      // cycles with rsp_ready low
    } entry_t;

    localparam int NUM_ENTRIES     = 23;
    localparam int RESET_CYCLES    = 10;
    localparam int WATCHDOG_CYCLES = NUM_ENTRIES * 1000 + RESET_CYCLES;

    logic               CLK;
    logic               RESET;
    logic               req_valid;
    eeprom_req_t        req;
    logic               req_ready;
    logic               rsp_valid;
    eeprom_rsp_t        rsp;
    logic               rsp_ready;
    logic               scl;
    logic               dut_pull_low;
    logic               model_pull_low;
    logic               sda;
    logic               busy;

    entry_t             stim [NUM_ENTRIES];
    logic [DATA_W-1:0]  shadow [0:(1 << ADDR_W) - 1];
    logic [31:0]        seed;
    int                 errors;
    int                 checks;

    assign sda = ~dut_pull_low & ~model_pull_low;      // wired AND

    i2c_eeprom_top UUT
    (
        .CLK            (CLK),
        .RESET          (RESET),
        .req_valid      (req_valid),
        .req            (req),
        .req_ready      (req_ready),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp),
        .rsp_ready      (rsp_ready),
        .scl            (scl),
        .sda_pull_low   (dut_pull_low),
        .sda_in         (sda)
    );

    eeprom_model EEPROM
    (
        .CLK            (CLK),
        .RESET          (RESET),
        .scl            (scl),
        .sda            (sda),
        .busy           (busy),
        .sda_pull_low   (model_pull_low)
    );

    always #4 CLK = ~CLK;

    function automatic logic [7:0] rand_byte();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[23:16];
    endfunction

    function automatic entry_t make_entry(input eeprom_op_e op, input logic [10:0] addr,
                                          input logic [7:0] data, input logic bsy,
                                          input logic [7:0] stall);
        entry_t e;
        e.op    = op;
        e.addr  = addr;
        e.data  = data;
        e.busy  = bsy;
        e.stall = stall;
        return e;
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_op(input string name, input eeprom_op_e exp, input eeprom_op_e act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("error %s: expected %s, actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_rsp(input string name, input eeprom_rsp_t exp, input eeprom_rsp_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic present_request(input entry_t e);
        req.op    = e.op;
        req.addr  = e.addr;
        req.data  = e.data;
        req_valid = 1'b1;
    endtask

    task automatic run_entry(input int idx, input entry_t e);
        eeprom_rsp_t    exp;
        string          name;
        int             i;
        name     = $sformatf("entry %0d %s addr %h", idx, e.op.name(), e.addr);
        exp.op   = e.op;
        exp.data = '0;
        exp.nack = e.busy;
        if ((e.op == OP_READ) && !e.busy)
            exp.data = shadow[e.addr];
        if ((e.op == OP_WRITE) && !e.busy)
            shadow[e.addr] = e.data;
        busy = e.busy;
        present_request(e);
        while (!req_ready)
            @(negedge CLK);
        @(negedge CLK);
        req_valid = 1'b0;
        while (!rsp_valid)
            @(negedge CLK);
        check_rsp(name, exp, rsp);
        check_op({name, " op"}, e.op, rsp.op);
        if (idx + 1 < NUM_ENTRIES)
            present_request(stim[idx + 1]);     // held off until the response transfers
        for (i = 0; i < int'(e.stall); i++)
        begin
            @(negedge CLK);
            check_bit({name, " stalled rsp_valid"}, 1'b1, rsp_valid);
            check_rsp({name, " stalled rsp"}, exp, rsp);
            check_bit({name, " stalled req_ready"}, 1'b0, req_ready);
            check_bit({name, " stalled scl"}, 1'b1, scl);
        end
        rsp_ready = 1'b1;
        @(negedge CLK);
        rsp_ready = 1'b0;
        busy      = 1'b0;
        check_bit({name, " rsp_valid after transfer"}, 1'b0, rsp_valid);
        check_bit({name, " req_ready after transfer"}, 1'b1, req_ready);
    endtask

    initial
    begin
        int         i;
        int         n;
        logic [7:0] lo;
        CLK       = 1'b0;
        RESET     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b0;
        busy      = 1'b0;
        errors    = 0;
        checks    = 0;
        seed      = 32'd98;
        for (i = 0; i < (1 << ADDR_W); i++)
            shadow[i] = 8'(i) ^ {3'(i), 5'(i >> 6)} ^ 8'h5a;

        stim[0] = make_entry(OP_WRITE, 11'h2a5, 8'h3c, 1'b0, 8'd0);
        stim[1] = make_entry(OP_READ, 11'h2a5, 8'h00, 1'b0, 8'd0);
        stim[2] = make_entry(OP_WRITE, 11'h2a5, 8'hff, 1'b1, 8'd0);    // refused
        stim[3] = make_entry(OP_READ, 11'h2a5, 8'h00, 1'b1, 8'd3);
        stim[4] = make_entry(OP_READ, 11'h2a5, 8'h00, 1'b0, 8'd0);
        stim[5] = make_entry(OP_WRITE, 11'h7ff, 8'h81, 1'b0, 8'd20);
        stim[6] = make_entry(OP_READ, 11'h7ff, 8'h00, 1'b0, 8'd35);
        n = 7;
        for (i = 0; i < 8; i++)
        begin
            lo = rand_byte();
            stim[n] = make_entry(OP_WRITE, {3'(i), lo}, rand_byte(), 1'b0, 8'(i));
            if (i % 2 == 1)
                lo = rand_byte();   // likely an address never written
            stim[n + 1] = make_entry(OP_READ, {3'(i), lo}, 8'h00, 1'b0, 8'(2 * i));
            n = n + 2;
        end

        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        check_bit("reset scl", 1'b1, scl);
        check_bit("reset sda_pull_low", 1'b0, dut_pull_low);
        check_bit("reset req_ready", 1'b1, req_ready);
        check_bit("reset rsp_valid", 1'b0, rsp_valid);

        for (i = 0; i < NUM_ENTRIES; i++)
            run_entry(i, stim[i]);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        $display("timeout: the DUT did not finish %0d requests in %0d cycles, errors %0d",
                 NUM_ENTRIES, WATCHDOG_CYCLES, errors);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* i2c_eeprom.f */
rtl/i2c_eeprom_pkg.sv
rtl/i2c_byte_phy.sv
rtl/eeprom_ctrl.sv
rtl/i2c_eeprom_top.sv
testbench/eeprom_model.sv
testbench/tb_i2c_eeprom.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_i2c_eeprom
FILELIST  ?= i2c_eeprom.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Regression passed" $(LOG) || { echo "no verdict found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
